// File: filelist.f
+incdir+verilog
verilog/core_pkg.sv
verilog/exu_stage_if.sv
verilog/operand_bypass.sv
verilog/alu_execute.sv
verilog/cdb_writeback.sv
verilog/alu_pipe_top.sv
verif/alu_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the ALU pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Mdir "$OBJ" --top-module alu_pipe_tb -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/Valu_pipe_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '>>> FAIL' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: verif/alu_pipe_tb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_pipe_tb import core_pkg::*; ();

    localparam int MAX_ENT = 64;
    localparam int N_TESTS = 5;

    // ============================================================
    // DUT signals
    // ============================================================
    logic               clk;
    logic               reset;
    logic               issue_valid;
    op_word_t           issue_op;
    logic [`PTAG_W-1:0] issue_dst_tag;
    logic [`ROB_W-1:0]  issue_rob_tag;
    logic               issue_src1_ready;
    logic [`PTAG_W-1:0] issue_src1_tag;
    logic [`XLEN-1:0]   issue_src1_val;
    logic               issue_src2_ready;
    logic [`PTAG_W-1:0] issue_src2_tag;
    logic [`XLEN-1:0]   issue_src2_val;
    logic               cdb_valid;
    logic [`PTAG_W-1:0] cdb_tag;
    logic [`XLEN-1:0]   cdb_value;
    logic               result_valid;
    logic [`PTAG_W-1:0] result_tag;
    logic [`XLEN-1:0]   result_value;
    logic [`ROB_W-1:0]  result_rob_tag;
    logic               bypass_valid;
    logic [`PTAG_W-1:0] bypass_tag;
    logic [`XLEN-1:0]   bypass_value;
    nzcv_t              flags;

    alu_pipe_top dut0 (.*);

    // One issue slot, stimulus plus modeled response
    typedef struct packed {
        logic [11:0]        op;
        logic [`PTAG_W-1:0] dst;
        logic [`ROB_W-1:0]  rob;
        logic               r1;
        logic [`PTAG_W-1:0] tag1;
        logic [`XLEN-1:0]   v1;
        logic               r2;
        logic [`PTAG_W-1:0] tag2;
        logic [`XLEN-1:0]   v2;
        logic               cdb_v;
        logic [`PTAG_W-1:0] cdb_tag;
        logic [`XLEN-1:0]   cdb_val;
        logic               exp_valid;
        logic [`XLEN-1:0]   exp_value;
        logic [3:0]         exp_flags;
        logic [7:0]         test;
    } entry_t;

    entry_t             tbl [MAX_ENT];
    int                 n_ent;
    int                 exp_q [$];
    logic [7:0]         build_test;
    logic [7:0]         cur_test;
    logic [3:0]         run_flags;
    logic [`PTAG_W-1:0] fill_tag;
    string              test_name [N_TESTS];
    int                 test_err [N_TESTS];
    int                 err_count;
    int                 n_checks;
    int                 tests_done;
    int                 tests_failed;
    int                 cycle_limit;
    int                 cycles;

    // ============================================================
    // Reference model
    // ============================================================
    function automatic void model_alu(input logic [11:0] op, input logic [`XLEN-1:0] a,
                                      input logic [`XLEN-1:0] b, output logic ok,
                                      output logic [`XLEN-1:0] res, output logic [3:0] f);
        logic [5:0] opc;
        logic [5:0] fn;
        longint     sr;
        logic       c;
        logic       v;
        opc = op[11:6];
        fn  = op[5:0];
        ok  = 1'b1;
        res = '0;
        c   = 1'b0;
        v   = 1'b0;
        sr  = 0;
        if (opc == R_TYPE) begin
            case (fn)
                ADD: begin
                    res = a + b;
                    // Unsigned wrap means a carry out
                    c   = (res < a);
                    sr  = longint'($signed(a)) + longint'($signed(b));
                end
                SUB, CMP: begin
                    res = a - b;
                    c   = (a >= b);
                    sr  = longint'($signed(a)) - longint'($signed(b));
                end
                AND:          res = a & b;
                ORR:          res = a | b;
                EOR:          res = a ^ b;
                NEG:          res = 32'd0 - a;
                LSL_R, LSL_I: res = a << b[4:0];
                LSR_R, LSR_I: res = a >> b[4:0];
                RET:          res = a;
                default:      ok = 1'b0;
            endcase
            // Exact signed result outside 32 bits
            v = (sr > 64'sd2147483647) || (sr < -64'sd2147483648);
        end else if (opc == ADDI) begin
            res = a + b;
            c   = (res < a);
        end else if (opc == SUBI) begin
            res = a - b;
            c   = (a >= b);
        end else if (opc == ANDI) begin
            res = a & b;
        end else if (opc == ORI) begin
            res = a | b;
        end else if (opc == EORI) begin
            res = a ^ b;
        end else begin
            ok = 1'b0;
        end
        f = {res[`XLEN-1], (res == '0), c, v};
    endfunction

    // Pending source lookup: slot n-2 is in execute, n-3 in writeback
    task automatic resolve_src(input logic [`PTAG_W-1:0] tag, input logic cv,
                               input logic [`PTAG_W-1:0] ctag, input logic [`XLEN-1:0] cval,
                               output logic hit, output logic [`XLEN-1:0] val);
        hit = 1'b1;
        val = '0;
        if (n_ent >= 2 && tbl[n_ent-2].exp_valid && tbl[n_ent-2].dst == tag)
            val = tbl[n_ent-2].exp_value;
        else if (n_ent >= 3 && tbl[n_ent-3].exp_valid && tbl[n_ent-3].dst == tag)
            val = tbl[n_ent-3].exp_value;
        else if (cv && ctag == tag)
            val = cval;
        else
            hit = 1'b0;
    endtask

    // ============================================================
    // Table construction
    // ============================================================
    task automatic add_op(input logic [5:0] opc, input logic [5:0] fn,
                          input logic [`PTAG_W-1:0] dst,
                          input logic r1, input logic [`PTAG_W-1:0] tag1,
                          input logic [`XLEN-1:0] v1,
                          input logic r2, input logic [`PTAG_W-1:0] tag2,
                          input logic [`XLEN-1:0] v2,
                          input logic cv, input logic [`PTAG_W-1:0] ctag,
                          input logic [`XLEN-1:0] cval);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic [3:0]       f;
        logic             ok;
        logic             hit1;
        logic             hit2;
        a    = v1;
        b    = v2;
        hit1 = 1'b1;
        hit2 = 1'b1;
        if (!r1)
            resolve_src(tag1, cv, ctag, cval, hit1, a);
        if (!r2)
            resolve_src(tag2, cv, ctag, cval, hit2, b);
        if (!hit1 || !hit2) begin
            $display("Table entry %0d has a pending operand that no bus supplies", n_ent);
            err_count++;
        end
        model_alu({opc, fn}, a, b, ok, res, f);
        // Flags register follows surviving CMPs only
        if (ok && opc == R_TYPE && fn == CMP)
            run_flags = f;
        tbl[n_ent] = '{op: {opc, fn}, dst: dst, rob: n_ent[`ROB_W-1:0],
                       r1: r1, tag1: tag1, v1: v1, r2: r2, tag2: tag2, v2: v2,
                       cdb_v: cv, cdb_tag: ctag, cdb_val: cval, exp_valid: ok,
                       exp_value: res, exp_flags: run_flags, test: build_test};
        n_ent++;
    endtask

    task automatic add_fixed(input logic [5:0] opc, input logic [5:0] fn,
                             input logic [`PTAG_W-1:0] dst,
                             input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2);
        add_op(opc, fn, dst, 1'b1, '0, v1, 1'b1, '0, v2, 1'b0, '0, '0);
    endtask

    // Filler tags stay in 1..31, away from the forwarding tags
    task automatic add_ready(input logic [5:0] opc, input logic [5:0] fn,
                             input logic [`XLEN-1:0] v1, input logic [`XLEN-1:0] v2);
        add_fixed(opc, fn, fill_tag, v1, v2);
        fill_tag = (fill_tag == 6'd31) ? 6'd1 : fill_tag + 6'd1;
    endtask

    task automatic build_table();
        logic [5:0] funcs [12];
        logic [5:0] iops [5];
        funcs = '{ADD, SUB, AND, ORR, EOR, NEG, CMP, LSL_R, LSR_R, LSL_I, LSR_I, RET};
        iops  = '{ADDI, SUBI, ANDI, ORI, EORI};
        n_ent      = 0;
        run_flags  = 4'h0;
        fill_tag   = 6'd1;
        test_name  = '{"reset", "alu_ops", "forwarding", "flags", "undefined"};
        // Every operation on random ready operands
        build_test = 8'd1;
        foreach (funcs[i])
            add_ready(R_TYPE, funcs[i], $urandom(), $urandom());
        foreach (iops[i])
            add_ready(iops[i], 6'h00, $urandom(), $urandom());
        // Producer two slots ahead, picked up from execute
        build_test = 8'd2;
        add_fixed(R_TYPE, ADD, 6'd40, $urandom(), $urandom());
        add_ready(R_TYPE, ORR, $urandom(), $urandom());
        add_op(R_TYPE, SUB, 6'd50, 1'b0, 6'd40, $urandom(), 1'b1, '0, $urandom(),
               1'b0, '0, '0);
        add_ready(R_TYPE, AND, $urandom(), $urandom());
        // Forwarded result forwarded again
        add_op(R_TYPE, EOR, 6'd51, 1'b1, '0, $urandom(), 1'b0, 6'd50, $urandom(),
               1'b0, '0, '0);
        // Producer three slots ahead, from writeback
        add_fixed(R_TYPE, SUB, 6'd41, $urandom(), $urandom());
        add_ready(R_TYPE, EOR, $urandom(), $urandom());
        add_ready(R_TYPE, ADD, $urandom(), $urandom());
        add_op(R_TYPE, ADD, 6'd52, 1'b1, '0, $urandom(), 1'b0, 6'd41, $urandom(),
               1'b0, '0, '0);
        // Only the external CDB holds tag 60
        add_op(R_TYPE, EOR, 6'd53, 1'b0, 6'd60, $urandom(), 1'b1, '0, $urandom(),
               1'b1, 6'd60, $urandom());
        // Same tag in execute, writeback and CDB, execute wins
        add_fixed(R_TYPE, ADD, 6'd42, $urandom(), $urandom());
        add_fixed(R_TYPE, SUB, 6'd42, $urandom(), $urandom());
        add_ready(R_TYPE, ORR, $urandom(), $urandom());
        add_op(R_TYPE, ORR, 6'd54, 1'b0, 6'd42, $urandom(), 1'b0, 6'd42, $urandom(),
               1'b1, 6'd42, $urandom());
        // Writeback beats CDB
        add_fixed(R_TYPE, EOR, 6'd43, $urandom(), $urandom());
        add_ready(R_TYPE, AND, $urandom(), $urandom());
        add_ready(R_TYPE, ADD, $urandom(), $urandom());
        add_op(R_TYPE, ADD, 6'd55, 1'b0, 6'd43, $urandom(), 1'b1, '0, $urandom(),
               1'b1, 6'd43, $urandom());
        // Carry and overflow corners, only CMP may move flags
        build_test = 8'd3;
        add_ready(R_TYPE, ADD, 32'h7fff_ffff, 32'h0000_0001);
        add_ready(R_TYPE, SUB, 32'h8000_0000, 32'h0000_0001);
        add_ready(R_TYPE, CMP, 32'h0000_0005, 32'h0000_0005);
        add_ready(R_TYPE, ADD, 32'hffff_ffff, 32'h0000_0001);
        add_ready(R_TYPE, CMP, 32'h8000_0000, 32'h0000_0001);
        add_ready(R_TYPE, SUB, 32'h0000_0000, 32'h0000_0000);
        add_ready(R_TYPE, CMP, 32'h0000_0001, 32'h0000_0002);
        add_ready(R_TYPE, CMP, 32'h7fff_ffff, 32'hffff_ffff);
        add_ready(R_TYPE, SUB, 32'h0000_0001, 32'h0000_0002);
        // Undefined words mixed with good ones back to back
        build_test = 8'd4;
        add_ready(6'h3f, ADD, $urandom(), $urandom());
        add_ready(R_TYPE, 6'h15, $urandom(), $urandom());
        add_ready(R_TYPE, ADD, $urandom(), $urandom());
        add_ready(6'h04, 6'h00, $urandom(), $urandom());
        add_ready(R_TYPE, ORR, $urandom(), $urandom());
        add_ready(R_TYPE, 6'h3f, $urandom(), $urandom());
        add_ready(R_TYPE, CMP, $urandom(), $urandom());
        add_ready(6'h10, CMP, $urandom(), $urandom());
        add_ready(R_TYPE, EOR, $urandom(), $urandom());
        cycle_limit = n_ent + 50;
    endtask

    // ============================================================
    // Drive and check
    // ============================================================
    task automatic drive_entry(input entry_t e);
        issue_valid      = 1'b1;
        issue_op         = e.op;
        issue_dst_tag    = e.dst;
        issue_rob_tag    = e.rob;
        issue_src1_ready = e.r1;
        issue_src1_tag   = e.tag1;
        issue_src1_val   = e.v1;
        issue_src2_ready = e.r2;
        issue_src2_tag   = e.tag2;
        issue_src2_val   = e.v2;
        cdb_valid        = e.cdb_v;
        cdb_tag          = e.cdb_tag;
        cdb_value        = e.cdb_val;
    endtask

    task automatic drive_idle();
        drive_entry('{r1: 1'b1, r2: 1'b1, default: '0});
        issue_valid = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h (test %0d)", name, got, exp, cur_test);
            err_count++;
            test_err[cur_test]++;
        end
    endtask

    task automatic report_test(input logic [7:0] id);
        tests_done++;
        if (test_err[id] == 0) begin
            $display("test %0d %s ok", id, test_name[id]);
        end else begin
            $display("test %0d %s failed with %0d errors", id, test_name[id], test_err[id]);
            tests_failed++;
        end
    endtask

    task automatic check_bypass(input int e);
        cur_test = tbl[e].test;
        check_value("bypass_valid", 32'(bypass_valid), 32'(tbl[e].exp_valid));
        if (tbl[e].exp_valid) begin
            check_value("bypass_tag", 32'(bypass_tag), 32'(tbl[e].dst));
            check_value("bypass_value", bypass_value, tbl[e].exp_value);
        end
    endtask

    task automatic check_result(input int e);
        cur_test = tbl[e].test;
        check_value("result_valid", 32'(result_valid), 32'(tbl[e].exp_valid));
        if (tbl[e].exp_valid) begin
            check_value("result_tag", 32'(result_tag), 32'(tbl[e].dst));
            check_value("result_value", result_value, tbl[e].exp_value);
            check_value("result_rob_tag", 32'(result_rob_tag), 32'(tbl[e].rob));
        end
        check_value("flags", {28'd0, flags}, {28'd0, tbl[e].exp_flags});
        // Last slot of a test closes it
        if (e == n_ent - 1 || tbl[e+1].test != tbl[e].test)
            report_test(tbl[e].test);
    endtask

    // ============================================================
    // Clock, timeout, main sequence
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        @(posedge clk);
        cycles = 1;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int c;
        reset = 1'b1;
        drive_idle();
        void'($urandom(32'hdac7_13a6));
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Nothing leaves the pipe before the first issue
        @(negedge clk);
        cur_test = 8'd0;
        check_value("result_valid", 32'(result_valid), 32'd0);
        check_value("bypass_valid", 32'(bypass_valid), 32'd0);
        check_value("flags", {28'd0, flags}, 32'd0);
        report_test(8'd0);
        // Slot c-3 sits in writeback, c-2 in execute
        for (c = 0; c < n_ent + 3; c++) begin
            @(negedge clk);
            if (c >= 3)
                check_result(exp_q.pop_front());
            if (c >= 2 && exp_q.size() > 0)
                check_bypass(exp_q[0]);
            if (c < n_ent) begin
                drive_entry(tbl[c]);
                exp_q.push_back(c);
            end else begin
                drive_idle();
            end
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_done, tests_failed, n_checks, err_count);
        if (err_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verilog/alu_pipe_top.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_pipe_top import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    // Issue from the reservation station
    input  logic               issue_valid,
    input  op_word_t           issue_op,
    input  logic [`PTAG_W-1:0] issue_dst_tag,
    input  logic [`ROB_W-1:0]  issue_rob_tag,
    input  logic               issue_src1_ready,
    input  logic [`PTAG_W-1:0] issue_src1_tag,
    input  logic [`XLEN-1:0]   issue_src1_val,
    input  logic               issue_src2_ready,
    input  logic [`PTAG_W-1:0] issue_src2_tag,
    input  logic [`XLEN-1:0]   issue_src2_val,

    // External CDB snoop
    input  logic               cdb_valid,
    input  logic [`PTAG_W-1:0] cdb_tag,
    input  logic [`XLEN-1:0]   cdb_value,

    // Result broadcast
    output logic               result_valid,
    output logic [`PTAG_W-1:0] result_tag,
    output logic [`XLEN-1:0]   result_value,
    output logic [`ROB_W-1:0]  result_rob_tag,

    // Early bypass from execute
    output logic               bypass_valid,
    output logic [`PTAG_W-1:0] bypass_tag,
    output logic [`XLEN-1:0]   bypass_value,

    output nzcv_t              flags
);

    // ============================================================
    // Stage links
    // ============================================================
    exu_stage_if s1 ();
    exu_stage_if s2 ();

    // Stage 1, writeback result loops back as plain ports
    operand_bypass u_operand_bypass (
        .clk              (clk),
        .reset            (reset),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_dst_tag    (issue_dst_tag),
        .issue_rob_tag    (issue_rob_tag),
        .issue_src1_ready (issue_src1_ready),
        .issue_src1_tag   (issue_src1_tag),
        .issue_src1_val   (issue_src1_val),
        .issue_src2_ready (issue_src2_ready),
        .issue_src2_tag   (issue_src2_tag),
        .issue_src2_val   (issue_src2_val),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .wb_valid         (result_valid),
        .wb_tag           (result_tag),
        .wb_value         (result_value),
        .bypass           (s2),
        .s1_out           (s1)
    );

    // Stage 2
    alu_execute u_alu_execute (
        .clk    (clk),
        .reset  (reset),
        .s1_in  (s1),
        .s2_out (s2)
    );

    // Stage 3
    cdb_writeback u_cdb_writeback (
        .clk            (clk),
        .reset          (reset),
        .s2_in          (s2),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value),
        .result_rob_tag (result_rob_tag),
        .flags          (flags)
    );

    // Bypass is the execute register itself
    assign bypass_valid = s2.valid;
    assign bypass_tag   = s2.dst_tag;
    assign bypass_value = s2.result;

endmodule

// File: verilog/cdb_writeback.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module cdb_writeback import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    exu_stage_if.sink          s2_in,

    // CDB broadcast
    output logic               result_valid,
    output logic [`PTAG_W-1:0] result_tag,
    output logic [`XLEN-1:0]   result_value,
    output logic [`ROB_W-1:0]  result_rob_tag,

    // Architectural condition flags
    output nzcv_t              flags
);

    // ============================================================
    // Flag update condition
    // ============================================================
    logic is_cmp;

    // Only a surviving CMP writes the flags
    assign is_cmp = s2_in.valid
                 && (s2_in.op.opcode == R_TYPE)
                 && (s2_in.op.func   == CMP);

    // ============================================================
    // Broadcast register
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid   <= 1'b0;
            result_tag     <= '0;
            result_value   <= '0;
            result_rob_tag <= '0;
        end else begin
            result_valid   <= s2_in.valid;
            result_tag     <= s2_in.dst_tag;
            result_value   <= s2_in.result;
            result_rob_tag <= s2_in.rob_tag;
        end
    end

    // ============================================================
    // Flags register
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (is_cmp) begin
            flags <= s2_in.nzcv;
        end
    end

    // Broadcast data must be clean while the strobe is up
    a_result_known: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> !$isunknown(result_value));

endmodule

// File: verilog/alu_execute.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_execute import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    exu_stage_if.sink   s1_in,
    exu_stage_if.source s2_out
);

    // ============================================================
    // Shared adder and subtractor
    // ============================================================
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN:0]   add_sum;
    logic [`XLEN:0]   sub_diff;
    logic             add_ovf;
    logic             sub_ovf;

    assign a = s1_in.src1;
    assign b = s1_in.src2;

    // Carry out lands in the top bit
    assign add_sum  = {1'b0, a} + {1'b0, b};
    // Two's complement subtract, top bit set means no borrow
    assign sub_diff = {1'b0, a} + {1'b0, ~b} + {{`XLEN{1'b0}}, 1'b1};

    // Signed overflow
    assign add_ovf = (a[`XLEN-1] == b[`XLEN-1]) && (add_sum[`XLEN-1] != a[`XLEN-1]);
    assign sub_ovf = (a[`XLEN-1] != b[`XLEN-1]) && (sub_diff[`XLEN-1] != a[`XLEN-1]);

    // ============================================================
    // Decode and result select
    // ============================================================
    logic [`XLEN-1:0] res;
    logic             op_ok;
    logic             c_flag;
    logic             v_flag;
    nzcv_t            flags_nxt;

    always_comb begin
        res    = '0;
        op_ok  = 1'b1;
        c_flag = 1'b0;
        v_flag = 1'b0;
        case (s1_in.op.opcode)
            R_TYPE: begin
                case (s1_in.op.func)
                    ADD: begin
                        res    = add_sum[`XLEN-1:0];
                        c_flag = add_sum[`XLEN];
                        v_flag = add_ovf;
                    end
                    // CMP keeps the difference on the bus as well
                    SUB, CMP: begin
                        res    = sub_diff[`XLEN-1:0];
                        c_flag = sub_diff[`XLEN];
                        v_flag = sub_ovf;
                    end
                    AND:          res = a & b;
                    ORR:          res = a | b;
                    EOR:          res = a ^ b;
                    NEG:          res = '0 - a;
                    // Register and immediate shifts share src2[4:0]
                    LSL_R, LSL_I: res = a << b[4:0];
                    LSR_R, LSR_I: res = a >> b[4:0];
                    // Return address pass-through
                    RET:          res = a;
                    default:      op_ok = 1'b0;
                endcase
            end
            // Immediate already sits in src2
            ADDI: begin
                res    = add_sum[`XLEN-1:0];
                c_flag = add_sum[`XLEN];
            end
            SUBI: begin
                res    = sub_diff[`XLEN-1:0];
                c_flag = sub_diff[`XLEN];
            end
            ANDI:    res = a & b;
            ORI:     res = a | b;
            EORI:    res = a ^ b;
            // Non-ALU op, flows on with no result
            default: begin
                res   = a;
                op_ok = 1'b0;
            end
        endcase

        flags_nxt.n = res[`XLEN-1];
        flags_nxt.z = (res == '0);
        flags_nxt.c = c_flag;
        flags_nxt.v = v_flag;
    end

    // ============================================================
    // Stage 2 register, also the bypass source
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s2_out.valid   <= 1'b0;
            s2_out.op      <= '0;
            s2_out.dst_tag <= '0;
            s2_out.rob_tag <= '0;
            s2_out.result  <= '0;
            s2_out.nzcv    <= '0;
        end else begin
            s2_out.valid   <= s1_in.valid && op_ok;
            s2_out.op      <= s1_in.op;
            s2_out.dst_tag <= s1_in.dst_tag;
            s2_out.rob_tag <= s1_in.rob_tag;
            s2_out.result  <= res;
            s2_out.nzcv    <= flags_nxt;
        end
    end

    // Operands are consumed here
    assign s2_out.src1 = '0;
    assign s2_out.src2 = '0;

    // A live op reaches execute with a fully known word and operands
    a_s1_known: assert property (@(posedge clk) disable iff (reset)
        s1_in.valid |-> !$isunknown({s1_in.op, s1_in.src1, s1_in.src2}));

endmodule

// File: verilog/operand_bypass.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module operand_bypass import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    // Issue from the reservation station
    input  logic               issue_valid,
    input  op_word_t           issue_op,
    input  logic [`PTAG_W-1:0] issue_dst_tag,
    input  logic [`ROB_W-1:0]  issue_rob_tag,
    input  logic               issue_src1_ready,
    input  logic [`PTAG_W-1:0] issue_src1_tag,
    input  logic [`XLEN-1:0]   issue_src1_val,
    input  logic               issue_src2_ready,
    input  logic [`PTAG_W-1:0] issue_src2_tag,
    input  logic [`XLEN-1:0]   issue_src2_val,

    // External common data bus
    input  logic               cdb_valid,
    input  logic [`PTAG_W-1:0] cdb_tag,
    input  logic [`XLEN-1:0]   cdb_value,

    // Own writeback stage
    input  logic               wb_valid,
    input  logic [`PTAG_W-1:0] wb_tag,
    input  logic [`XLEN-1:0]   wb_value,

    exu_stage_if.sink          bypass,
    exu_stage_if.source        s1_out
);

    // ============================================================
    // Tag match against the three result buses
    // ============================================================
    logic             bp_hit1, wb_hit1, cdb_hit1;
    logic             bp_hit2, wb_hit2, cdb_hit2;
    logic [`XLEN-1:0] src1_sel;
    logic [`XLEN-1:0] src2_sel;

    // Execute bypass holds the op one ahead of writeback
    assign bp_hit1  = bypass.valid && (bypass.dst_tag == issue_src1_tag);
    assign wb_hit1  = wb_valid     && (wb_tag         == issue_src1_tag);
    assign cdb_hit1 = cdb_valid    && (cdb_tag        == issue_src1_tag);

    assign bp_hit2  = bypass.valid && (bypass.dst_tag == issue_src2_tag);
    assign wb_hit2  = wb_valid     && (wb_tag         == issue_src2_tag);
    assign cdb_hit2 = cdb_valid    && (cdb_tag        == issue_src2_tag);

    // Youngest producer first: bypass, then writeback, then CDB
    always_comb begin
        if (issue_src1_ready)
            src1_sel = issue_src1_val;
        else if (bp_hit1)
            src1_sel = bypass.result;
        else if (wb_hit1)
            src1_sel = wb_value;
        else if (cdb_hit1)
            src1_sel = cdb_value;
        else
            src1_sel = issue_src1_val;
    end

    always_comb begin
        if (issue_src2_ready)
            src2_sel = issue_src2_val;
        else if (bp_hit2)
            src2_sel = bypass.result;
        else if (wb_hit2)
            src2_sel = wb_value;
        else if (cdb_hit2)
            src2_sel = cdb_value;
        else
            src2_sel = issue_src2_val;
    end

    // ============================================================
    // Stage 1 register
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_out.valid   <= 1'b0;
            s1_out.op      <= '0;
            s1_out.dst_tag <= '0;
            s1_out.rob_tag <= '0;
            s1_out.src1    <= '0;
            s1_out.src2    <= '0;
        end else begin
            s1_out.valid   <= issue_valid;
            s1_out.op      <= issue_op;
            s1_out.dst_tag <= issue_dst_tag;
            s1_out.rob_tag <= issue_rob_tag;
            s1_out.src1    <= src1_sel;
            s1_out.src2    <= src2_sel;
        end
    end

    // Result fields only get filled at execute
    assign s1_out.result = '0;
    assign s1_out.nzcv   = '0;

    // RS may only issue a pending source that some bus supplies now
    a_src1_supplied: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_src1_ready) |-> (bp_hit1 || wb_hit1 || cdb_hit1));
    a_src2_supplied: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_src2_ready) |-> (bp_hit2 || wb_hit2 || cdb_hit2));

endmodule

// File: verilog/exu_stage_if.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

// One in-flight operation between two pipe stages
interface exu_stage_if import core_pkg::*; ();

    // Control and tags
    logic               valid;
    op_word_t           op;
    logic [`PTAG_W-1:0] dst_tag;
    logic [`ROB_W-1:0]  rob_tag;

    // Resolved operands, filled by stage 1
    logic [`XLEN-1:0]   src1;
    logic [`XLEN-1:0]   src2;

    // Result and flags, filled by execute
    logic [`XLEN-1:0]   result;
    nzcv_t              nzcv;

    // Producing stage
    modport source (
        output valid, op, dst_tag, rob_tag,
        output src1, src2,
        output result, nzcv
    );

    // Consuming stage, also the bypass reader
    modport sink (
        input valid, op, dst_tag, rob_tag,
        input src1, src2,
        input result, nzcv
    );

endinterface

// File: verilog/core_pkg.sv
package core_pkg;

    // ============================================================
    // Op word encodings
    // ============================================================

    // Major opcode, upper six bits of the op word
    typedef enum logic [5:0] {
        R_TYPE = 6'b000000,
        ADDI   = 6'b001000,
        SUBI   = 6'b001001,
        ANDI   = 6'b001010,
        ORI    = 6'b001011,
        EORI   = 6'b001100
    } opcode_e;

    // Function code, only meaningful under R_TYPE
    typedef enum logic [5:0] {
        LSL_R  = 6'b000000,
        LSL_I  = 6'b000001,
        LSR_R  = 6'b000010,
        LSR_I  = 6'b000011,
        ADD    = 6'b100000,
        SUB    = 6'b100010,
        AND    = 6'b100100,
        ORR    = 6'b100101,
        EOR    = 6'b100110,
        NEG    = 6'b101000,
        CMP    = 6'b101010,
        RET    = 6'b111000
    } func_e;

    // 12-bit op word as issued by the reservation station
    typedef struct packed {
        opcode_e opcode;
        func_e   func;
    } op_word_t;

    // Condition flags, ARM style ordering
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

endpackage

// File: verilog/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ============================================================
// Core widths
// ============================================================

// Integer datapath width
`define XLEN 32

// Physical register tag, 64 entries
`define PTAG_W 6

// Reorder buffer index, 64 entries
`define ROB_W 6

`endif
